/* hw/soc_pkg.sv */
// Shared types for the PC-style system bus fabric
// Word addresses carry byte address bits 19 to 1, so bit 0 of a byte
// address never appears on the bus; the byte selects stand in for it
// Every bus cycle travels as one request struct and one response struct

package soc_pkg;

  // 16-bit bus data word
  typedef logic [15:0] word_t;

  // Flash or switch byte
  typedef logic [7:0] byte_t;

  // Word address, indexed by byte address bit
  typedef logic [19:1] waddr_t;

  // Byte selects, bit 0 is the low byte
  typedef logic [1:0] sel_t;

  // Interrupt request lines and interrupt number
  typedef logic [7:0] irq_vec_t;
  typedef logic [2:0] iid_t;

  // Flash byte address, 64K words of two bytes
  typedef logic [16:0] flash_addr_t;

  // Master to fabric
  typedef struct packed {
    waddr_t adr;
    word_t  dat;
    logic   we;
    logic   tga;   // 1 for I/O space
    sel_t   sel;
    logic   stb;
    logic   cyc;
  } bus_req_t;

  // Slave or fabric back to master
  typedef struct packed {
    word_t dat;
    logic  ack;
  } bus_rsp_t;

endpackage

/* hw/pit_timer.sv */
// Periodic tick for interrupt source 0
// One-cycle tick every PIT_PERIOD clocks, first one PIT_PERIOD clocks
// after reset release
// PIT_PERIOD must be 2 or more

`timescale 1ns/1ps

module pit_timer #(
  parameter int PIT_PERIOD = 1000
) (
  input  logic clk,
  input  logic arst_n_i,
  output logic tick_o
);

  localparam int CW = $clog2(PIT_PERIOD);
  localparam logic [CW-1:0] RELOAD = CW'(PIT_PERIOD - 1);

  logic [CW-1:0] cnt_q;
  logic          tick_q;

  // Down-counter, tick on the reload edge
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q  <= RELOAD;
      tick_q <= 1'b0;
    end else if (cnt_q == '0) begin
      cnt_q  <= RELOAD;
      tick_q <= 1'b1;
    end else begin
      cnt_q  <= cnt_q - CW'(1);
      tick_q <= 1'b0;
    end
  end

  assign tick_o = tick_q;

endmodule

/* hw/simple_pic.sv */
// Eight-input priority interrupt controller
// Rising edges latch into pending bits, lowest number wins
// A one-cycle inta_i clears the bit reported on iid_o
// Level-held requests raise only one interrupt per edge

`timescale 1ns/1ps

module simple_pic
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  irq_vec_t irq_i,
  input  logic     inta_i,
  output logic     intr_o,
  output iid_t     iid_o
);

  irq_vec_t irq_q;
  irq_vec_t pend_q;
  irq_vec_t rise;
  irq_vec_t clr;

  // Edge detect against last cycle's lines
  assign rise = irq_i & ~irq_q;

  // Acknowledge drops only the reported bit
  assign clr = inta_i ? irq_vec_t'(8'b1 << iid_o) : '0;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      irq_q  <= '0;
      pend_q <= '0;
    end else begin
      irq_q  <= irq_i;
      // A fresh edge wins over a clear
      pend_q <= (pend_q & ~clr) | rise;
    end
  end

  // Priority encoder scanned from the top so bit 0 ends up first
  always_comb begin
    iid_o = '0;
    for (int i = 7; i >= 0; i--) begin
      if (pend_q[i]) begin
        iid_o = iid_t'(i);
      end
    end
  end

  assign intr_o = |pend_q;

  // Acknowledge only comes for a live request at iid_o
  a_inta_pending: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    inta_i |-> pend_q[iid_o]
  );

endmodule

/* hw/sys_ram.sv */
// On-chip word RAM with byte-lane writes
// Index is the low RAM_AW word address bits, higher bits alias
// RAM_AW must not exceed 19
// Ack one cycle after the strobe, then low for a cycle so a held
// strobe is never acknowledged twice

`timescale 1ns/1ps

module sys_ram
  import soc_pkg::*;
#(
  parameter int RAM_AW = 10
) (
  input  logic     clk,
  input  logic     arst_n_i,
  input  bus_req_t req_i,
  input  logic     stb_i,
  output bus_rsp_t rsp_o
);

  word_t             mem [2**RAM_AW];
  logic [RAM_AW-1:0] idx;
  logic              access;
  word_t             rdat_q;
  logic              ack_q;

  assign idx    = req_i.adr[RAM_AW:1];
  assign access = stb_i & !ack_q;

  // Array and read register
  always_ff @(posedge clk) begin
    if (access && req_i.we) begin
      if (req_i.sel[0]) begin
        mem[idx][7:0] <= req_i.dat[7:0];
      end
      if (req_i.sel[1]) begin
        mem[idx][15:8] <= req_i.dat[15:8];
      end
    end
    rdat_q <= mem[idx];
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign rsp_o.dat = rdat_q;
  assign rsp_o.ack = ack_q;

  // Master holds the strobe through the ack cycle
  a_ack_with_stb: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    rsp_o.ack |-> stb_i
  );

endmodule

/* hw/flash_reader.sv */
// Reads 16-bit words from an 8-bit flash as two byte reads
// Low byte first at byte bit 0, then high byte at byte bit 1
// Each byte is sampled after FLASH_WAIT+1 cycles on the address
// Flash writes are acknowledged and dropped
// Assumes the master keeps the strobe and address steady until ack
// Ack is a one-cycle pulse, read latency is 2*(FLASH_WAIT+1)+1 cycles

`timescale 1ns/1ps

module flash_reader
  import soc_pkg::*;
#(
  parameter int FLASH_WAIT = 2
) (
  input  logic        clk,
  input  logic        arst_n_i,
  input  bus_req_t    req_i,
  input  logic        stb_i,
  output bus_rsp_t    rsp_o,
  output flash_addr_t flash_addr_o,
  input  byte_t       flash_data_i
);

  // Counter holds FLASH_WAIT down to zero, with room when it is 0
  localparam int CW = $clog2(FLASH_WAIT + 2);
  localparam logic [CW-1:0] WAIT_LD = CW'(FLASH_WAIT);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOW,
    ST_HIGH,
    ST_DONE
  } state_e;

  state_e        state_q;
  logic [CW-1:0] cnt_q;
  logic          cnt_zero;
  byte_t         lo_q;
  byte_t         hi_q;

  assign cnt_zero = (cnt_q == '0);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= ST_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (stb_i) begin
            // Writes go straight to the ack
            if (req_i.we) begin
              state_q <= ST_DONE;
            end else begin
              state_q <= ST_LOW;
              cnt_q   <= WAIT_LD;
            end
          end
        end
        ST_LOW: begin
          if (cnt_zero) begin
            state_q <= ST_HIGH;
            cnt_q   <= WAIT_LD;
          end else begin
            cnt_q <= cnt_q - CW'(1);
          end
        end
        ST_HIGH: begin
          if (cnt_zero) begin
            state_q <= ST_DONE;
          end else begin
            cnt_q <= cnt_q - CW'(1);
          end
        end
        default: begin
          // Ack cycle, back to idle
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // Byte capture at the end of each wait window
  always_ff @(posedge clk) begin
    if (state_q == ST_LOW && cnt_zero) begin
      lo_q <= flash_data_i;
    end
    if (state_q == ST_HIGH && cnt_zero) begin
      hi_q <= flash_data_i;
    end
  end

  // Low byte address also shows while idle
  assign flash_addr_o = {req_i.adr[16:1], state_q == ST_HIGH};

  assign rsp_o.dat = {hi_q, lo_q};
  assign rsp_o.ack = (state_q == ST_DONE);

  // Master must still hold the strobe when the ack comes out
  a_ack_with_stb: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    rsp_o.ack |-> stb_i
  );

endmodule

/* hw/bus_decoder.sv */
// Address decode and response steering for the system bus
// Memory segments C and F go to flash, all other memory goes to RAM
// I/O ports are answered here with a combinational ack
// LED latch at ports F1xx ignores the byte selects on writes
// Interrupt acknowledge overrides the read data with the vector
// Read data is only meaningful while ack is high

`timescale 1ns/1ps

module bus_decoder
  import soc_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n_i,
  input  bus_req_t req_i,
  input  logic     inta_i,
  input  iid_t     iid_i,
  input  byte_t    sw_i,
  input  bus_rsp_t ram_rsp_i,
  input  bus_rsp_t flash_rsp_i,
  output logic     ram_stb_o,
  output logic     flash_stb_o,
  output bus_rsp_t rsp_o,
  output word_t    led_o
);

  logic  active;
  logic  flash_mem_arena;
  logic  ram_mem_arena;
  logic  led_io_arena;
  logic  sw_io_arena;
  logic  io_ack;
  word_t io_dat;
  word_t led_q;

  // Strobe and cycle together mark a live bus cycle
  assign active = req_i.stb & req_i.cyc;

  // Segments C000 and F000 map to flash
  assign flash_mem_arena = (req_i.adr[19:16] == 4'hc) || (req_i.adr[19:16] == 4'hf);
  assign ram_mem_arena   = !flash_mem_arena;

  // I/O ports
  assign led_io_arena = (req_i.adr[15:8] == 8'hf1);
  assign sw_io_arena  = (req_i.adr[15:1] == 15'h0081);

  // Per-slave strobes for memory space only
  assign flash_stb_o = active & !req_i.tga & flash_mem_arena;
  assign ram_stb_o   = active & !req_i.tga & ram_mem_arena;

  // Every I/O port answers in the same cycle
  assign io_ack = active & req_i.tga;

  // Switches zero-extended while LED and unmapped ports float high
  assign io_dat = sw_io_arena ? {8'h00, sw_i} : 16'hffff;

  // Response steering
  always_comb begin
    if (req_i.tga) begin
      rsp_o.ack = io_ack;
    end else if (flash_mem_arena) begin
      rsp_o.ack = flash_rsp_i.ack;
    end else begin
      rsp_o.ack = ram_rsp_i.ack;
    end

    // Vector is 8 plus the interrupt number
    if (inta_i) begin
      rsp_o.dat = {13'd1, iid_i};
    end else if (req_i.tga) begin
      rsp_o.dat = io_dat;
    end else if (flash_mem_arena) begin
      rsp_o.dat = flash_rsp_i.dat;
    end else begin
      rsp_o.dat = ram_rsp_i.dat;
    end
  end

  // LED latch loaded on the edge that sees the ack
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      led_q <= '0;
    end else if (io_ack && req_i.we && led_io_arena) begin
      led_q <= req_i.dat;
    end
  end

  assign led_o = led_q;

  // Selected slave only answers inside a live cycle
  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    rsp_o.ack |-> active
  );

endmodule

/* hw/soc_bus_top.sv */
// Bus fabric top level, one clock domain
// Memory: flash in segments C and F, RAM everywhere else
// I/O: LED latch at F1xx, switches at 0102, others read FFFF
// Timer tick is interrupt source 0, irq_i bit 0 is not used
// Flash is read only, writes are acknowledged and ignored

`timescale 1ns/1ps

module soc_bus_top
  import soc_pkg::*;
#(
  parameter int RAM_AW     = 10,
  parameter int FLASH_WAIT = 2,
  parameter int PIT_PERIOD = 1000
) (
  input  logic        clk,
  input  logic        arst_n_i,
  input  bus_req_t    bus_req_i,
  output bus_rsp_t    bus_rsp_o,
  input  logic        inta_i,
  output logic        intr_o,
  input  irq_vec_t    irq_i,
  input  byte_t       sw_i,
  output word_t       led_o,
  output flash_addr_t flash_addr_o,
  input  byte_t       flash_data_i
);

  logic     ram_stb;
  logic     flash_stb;
  bus_rsp_t ram_rsp;
  bus_rsp_t flash_rsp;
  logic     tick;
  irq_vec_t intv;
  iid_t     iid;

  // Timer takes over request line 0
  assign intv = {irq_i[7:1], tick};

  bus_decoder u_decoder (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_i       (bus_req_i),
    .inta_i      (inta_i),
    .iid_i       (iid),
    .sw_i        (sw_i),
    .ram_rsp_i   (ram_rsp),
    .flash_rsp_i (flash_rsp),
    .ram_stb_o   (ram_stb),
    .flash_stb_o (flash_stb),
    .rsp_o       (bus_rsp_o),
    .led_o       (led_o)
  );

  flash_reader #(
    .FLASH_WAIT (FLASH_WAIT)
  ) u_flash (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .req_i        (bus_req_i),
    .stb_i        (flash_stb),
    .rsp_o        (flash_rsp),
    .flash_addr_o (flash_addr_o),
    .flash_data_i (flash_data_i)
  );

  sys_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .req_i    (bus_req_i),
    .stb_i    (ram_stb),
    .rsp_o    (ram_rsp)
  );

  pit_timer #(
    .PIT_PERIOD (PIT_PERIOD)
  ) u_pit (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .tick_o   (tick)
  );

  simple_pic u_pic (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .irq_i    (intv),
    .inta_i   (inta_i),
    .intr_o   (intr_o),
    .iid_o    (iid)
  );

endmodule

/* tests/tb_soc_bus.sv */
// Testbench for the bus fabric, acting as the CPU bus master
// Flash model returns flash address bits 7 to 0 XOR 5A after 1 ns
// RAM_AW stays at 10, so RAM word addresses alias every 1024 words
// Interrupt tests assume no external request except the priority pair

`timescale 1ns/1ps

module tb_soc_bus
  import soc_pkg::*;
();

  localparam int    RAM_AW     = 10;
  localparam int    FLASH_WAIT = 2;
  localparam int    PIT_PERIOD = 200;
  localparam int    BUS_LIMIT  = 50;
  localparam int    TICKS      = 4;
  localparam byte_t SW_VAL     = 8'h96;
  localparam word_t LED_VAL    = 16'ha5c3;

  // One bus cycle of the table, exp only used for reads
  typedef struct packed {
    logic   tga;
    logic   we;
    waddr_t adr;
    word_t  dat;
    sel_t   sel;
    word_t  exp;
  } entry_t;

  logic        clk = 1'b0;
  logic        rst_n;
  bus_req_t    bus_req;
  bus_rsp_t    bus_rsp;
  logic        inta;
  logic        intr;
  irq_vec_t    irq;
  byte_t       sw;
  word_t       led;
  flash_addr_t flash_addr;
  byte_t       flash_data;

  entry_t tbl[$];
  logic   tbl_ready = 1'b0;
  int     seed = 31;
  int     errors = 0;
  int     checks = 0;
  int     cyc_cnt = 0;

  always #5 clk = ~clk;

  always @(posedge clk) cyc_cnt <= cyc_cnt + 1;

  // Behavioural 8-bit flash
  assign #1 flash_data = flash_addr[7:0] ^ 8'h5a;

  soc_bus_top #(
    .RAM_AW     (RAM_AW),
    .FLASH_WAIT (FLASH_WAIT),
    .PIT_PERIOD (PIT_PERIOD)
  ) uut (
    .clk          (clk),
    .arst_n_i     (rst_n),
    .bus_req_i    (bus_req),
    .bus_rsp_o    (bus_rsp),
    .inta_i       (inta),
    .intr_o       (intr),
    .irq_i        (irq),
    .sw_i         (sw),
    .led_o        (led),
    .flash_addr_o (flash_addr),
    .flash_data_i (flash_data)
  );

  // Byte address to bus word address
  function automatic waddr_t word_addr(input logic [19:0] byte_adr);
    return byte_adr[19:1];
  endfunction

  // Word read from flash: high byte at byte bit 1, low at byte bit 0
  function automatic word_t flash_word(input waddr_t adr);
    byte_t lo;
    byte_t hi;
    lo = {adr[7:1], 1'b0} ^ 8'h5a;
    hi = {adr[7:1], 1'b1} ^ 8'h5a;
    return {hi, lo};
  endfunction

  function automatic word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[15:0];
  endfunction

  function automatic void add_entry(input logic tga, input logic we,
                                    input logic [19:0] badr, input word_t dat,
                                    input sel_t sel, input word_t exp);
    tbl.push_back('{tga, we, word_addr(badr), dat, sel, exp});
  endfunction

  task automatic build_table();
    word_t       d[4];
    word_t       b;
    logic [19:0] ram_adr[4];
    logic [19:0] fl_adr[4];
    ram_adr = '{20'h00200, 20'h0123a, 20'h2f7fe, 20'h9abc4};
    fl_adr  = '{20'hc0124, 20'hc7ffe, 20'hf0a56, 20'hfffee};
    // Random full words, written then read back
    for (int i = 0; i < 4; i++) begin
      d[i] = rand_word();
      add_entry(1'b0, 1'b1, ram_adr[i], d[i], 2'b11, 16'h0000);
    end
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b0, 1'b0, ram_adr[i], 16'h0000, 2'b11, d[i]);
    end
    // Single lanes, other byte keeps its old value
    b = rand_word();
    add_entry(1'b0, 1'b1, ram_adr[0], b, 2'b01, 16'h0000);
    add_entry(1'b0, 1'b0, ram_adr[0], 16'h0000, 2'b11, {d[0][15:8], b[7:0]});
    b = rand_word();
    add_entry(1'b0, 1'b1, ram_adr[1], b, 2'b10, 16'h0000);
    add_entry(1'b0, 1'b0, ram_adr[1], 16'h0000, 2'b11, {b[15:8], d[1][7:0]});
    // One RAM size above lands on the same word
    b = rand_word();
    add_entry(1'b0, 1'b1, ram_adr[2] + 20'(2 ** (RAM_AW + 1)), b, 2'b11, 16'h0000);
    add_entry(1'b0, 1'b0, ram_adr[2], 16'h0000, 2'b11, b);
    // Flash in segments C and F
    for (int i = 0; i < 4; i++) begin
      add_entry(1'b0, 1'b0, fl_adr[i], 16'h0000, 2'b11, flash_word(word_addr(fl_adr[i])));
    end
    // Write is dropped, data stays as the model gives it
    add_entry(1'b0, 1'b1, fl_adr[0], 16'hbeef, 2'b11, 16'h0000);
    add_entry(1'b0, 1'b0, fl_adr[0], 16'h0000, 2'b11, flash_word(word_addr(fl_adr[0])));
    // I/O ports, LED write with no byte selects
    add_entry(1'b1, 1'b1, 20'h0f140, LED_VAL, 2'b00, 16'h0000);
    add_entry(1'b1, 1'b0, 20'h0f100, 16'h0000, 2'b11, 16'hffff);
    add_entry(1'b1, 1'b0, 20'h00102, 16'h0000, 2'b11, {8'h00, SW_VAL});
    add_entry(1'b1, 1'b0, 20'h00060, 16'h0000, 2'b11, 16'hffff);
    add_entry(1'b1, 1'b0, 20'h003f8, 16'h0000, 2'b11, 16'hffff);
  endtask

  task automatic check_value(input string what, input word_t got, input word_t exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Request held until ack is seen, then dropped for one idle cycle
  task automatic bus_cycle(input entry_t e, output word_t rdat, output logic acked);
    int n;
    n     = 0;
    acked = 1'b0;
    rdat  = '0;
    @(posedge clk);
    bus_req <= '{adr: e.adr, dat: e.dat, we: e.we, tga: e.tga, sel: e.sel,
                 stb: 1'b1, cyc: 1'b1};
    while (!acked && n < BUS_LIMIT) begin
      @(negedge clk);
      if (bus_rsp.ack) begin
        acked = 1'b1;
        rdat  = bus_rsp.dat;
      end
      n++;
    end
    @(posedge clk);
    bus_req.stb <= 1'b0;
    bus_req.cyc <= 1'b0;
  endtask

  // One-cycle acknowledge pulse, vector sampled mid-cycle
  task automatic inta_cycle(output word_t vec);
    @(posedge clk);
    inta <= 1'b1;
    @(negedge clk);
    vec = bus_rsp.dat;
    @(posedge clk);
    inta <= 1'b0;
  endtask

  task automatic wait_intr(input int limit);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!intr && n < limit);
    checks++;
    assert (intr) else begin
      errors++;
      $display("Timeout at %0t: intr_o stayed low for %0d cycles", $time, limit);
    end
  endtask

  initial begin
    word_t rdat;
    word_t vec;
    logic  acked;
    int    ticks;
    int    end_cyc;
    rst_n   = 1'b0;
    bus_req = '0;
    inta    = 1'b0;
    irq     = '0;
    sw      = SW_VAL;
    build_table();
    tbl_ready = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_value("ack after reset", {15'd0, bus_rsp.ack}, 16'h0000);
    check_value("intr_o after reset", {15'd0, intr}, 16'h0000);
    check_value("led_o after reset", led, 16'h0000);

    foreach (tbl[i]) begin
      bus_cycle(tbl[i], rdat, acked);
      checks++;
      assert (acked) else begin
        errors++;
        $display("Bus timeout at %0t: entry %0d got no ack in %0d cycles", $time, i, BUS_LIMIT);
      end
      if (acked && !tbl[i].we) begin
        check_value($sformatf("entry %0d at %h", i, tbl[i].adr), rdat, tbl[i].exp);
      end
    end
    check_value("led_o after LED write", led, LED_VAL);

    // First timer tick
    wait_intr(PIT_PERIOD + BUS_LIMIT);
    inta_cycle(vec);
    check_value("timer vector", vec, 16'h0008);
    @(negedge clk);
    check_value("intr_o after timer ack", {15'd0, intr}, 16'h0000);

    // Two requests at once, lower number first
    @(posedge clk);
    irq <= 8'b0010_1000;
    wait_intr(BUS_LIMIT);
    inta_cycle(vec);
    check_value("first priority vector", vec, 16'h000b);
    @(negedge clk);
    check_value("intr_o with irq 5 left", {15'd0, intr}, 16'h0001);
    inta_cycle(vec);
    check_value("second priority vector", vec, 16'h000d);
    @(negedge clk);
    check_value("intr_o after both acks", {15'd0, intr}, 16'h0000);
    @(posedge clk);
    irq <= '0;

    // Recurring ticks, counted by acknowledge
    ticks   = 0;
    end_cyc = cyc_cnt + TICKS * PIT_PERIOD;
    while (cyc_cnt < end_cyc) begin
      @(negedge clk);
      if (intr) begin
        inta_cycle(vec);
        check_value("recurring timer vector", vec, 16'h0008);
        ticks++;
      end
    end
    checks++;
    assert (ticks >= TICKS - 1 && ticks <= TICKS + 1) else begin
      errors++;
      $display("ERR %0t: %0d ticks in %0d cycles, expected %0d", $time, ticks,
               TICKS * PIT_PERIOD, TICKS);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Limit scales with the table, plus room for the timer tests
  initial begin
    wait (tbl_ready);
    repeat (tbl.size() * 60 + 2000) @(posedge clk);
    $display("Watchdog expired at %0t, the run did not finish", $time);
    $display("Checks: %0d, errors: %0d", checks, errors);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* soc_bus_top.f */
hw/soc_pkg.sv
hw/pit_timer.sv
hw/simple_pic.sv
hw/sys_ram.sv
hw/flash_reader.sv
hw/bus_decoder.sv
hw/soc_bus_top.sv
tests/tb_soc_bus.sv

/* Makefile */
# Verilator build and run for the bus fabric testbench
# Override any variable on the command line, e.g. make run LOG=my.log

VERILATOR ?= verilator
TOP       ?= tb_soc_bus
FILELIST  ?= soc_bus_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
